//--- direction_top.f
+incdir+test
design/direction_pkg.sv
design/frame_buffer.sv
design/frame_scanner.sv
design/division_histogram.sv
design/direction_select.sv
design/direction_top.sv
test/tb_direction.sv

//--- Bender.yml
package:
  name: direction_top

sources:
  - files:
      - design/direction_pkg.sv
      - design/frame_buffer.sv
      - design/frame_scanner.sv
      - design/division_histogram.sv
      - design/direction_select.sv
      - design/direction_top.sv
  - target: simulation
    include_dirs:
      - test
    files:
      - test/tb_direction.sv

//--- test/tb_direction_checks.svh
`ifndef TB_DIRECTION_CHECKS_SVH
`define TB_DIRECTION_CHECKS_SVH

// Ends the run at the first error
task automatic stop_on_error();
    errors++;
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_direction(input string name, input direction_t expected,
                               input direction_t actual);
    if (actual !== expected) begin
        $display("Fail %s: expected found=%0b bearing=%0d, actual found=%0b bearing=%0d",
                 name, expected.found, expected.bearing, actual.found, actual.bearing);
        stop_on_error();
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("Fail %s: expected %0b, actual %0b", name, expected, actual);
        stop_on_error();
    end
endtask

// Bright pixels per division, then argmax and the minimum-count rule
task automatic predict_direction(output direction_t prediction);
    int bright_count [NUM_DIVISIONS];
    int division;
    int winner;
    for (int d = 0; d < NUM_DIVISIONS; d++) begin
        bright_count[d] = 0;
    end
    for (int p = 0; p < IMAGE_PIXELS; p++) begin
        if (frame[p].red >= RED_THRESHOLD) begin
            division = (p % IMAGE_WIDTH) / DIVISION_WIDTH;
            bright_count[division]++;
        end
    end
    winner = 0;     // Lowest index wins a tie
    for (int d = 1; d < NUM_DIVISIONS; d++) begin
        if (bright_count[d] > bright_count[winner]) begin
            winner = d;
        end
    end
    if (bright_count[winner] < MIN_OBJECT_PIXELS) begin
        prediction = '0;
    end else begin
        prediction.found   = 1'b1;
        prediction.bearing = DEG_W'(winner * FOV_DIVISION_DEG + FOV_DIVISION_DEG / 2);
    end
endtask

`endif

//--- test/tb_direction.sv
`timescale 1ns/100ps

module tb_direction;
    import direction_pkg::*;

    localparam int FRAME_CYCLES    = 2 * IMAGE_PIXELS + 16;    // Write plus scan
    localparam int WATCHDOG_CYCLES = 10 * FRAME_CYCLES;

    logic       clk;
    logic       rst;
    cam_pixel_t cam_in;
    logic       busy;
    direction_t result;
    logic       result_valid;

    pixel_t frame [IMAGE_PIXELS];   // Next frame to send
    integer seed;
    int     errors;
    int     idle_cycles;

    `include "tb_direction_checks.svh"

    direction_top dut (
        .clk          (clk),
        .rst          (rst),
        .cam_in       (cam_in),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog, restarted by every result
    initial begin
        idle_cycles = 0;
        forever begin
            @(negedge clk);
            if (rst || result_valid) begin
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
            if (idle_cycles > WATCHDOG_CYCLES) begin
                $display("Timeout: the result of a frame never arrived");
                stop_on_error();
            end
        end
    end

    function automatic direction_t direction_of(input logic found, input int bearing);
        direction_t d;
        d.found   = found;
        d.bearing = DEG_W'(bearing);
        return d;
    endfunction

    // Background with red below the threshold everywhere
    task automatic clear_frame();
        logic [ADDR_W-1:0] fold;
        for (int p = 0; p < IMAGE_PIXELS; p++) begin
            fold = ADDR_W'(p) ^ (ADDR_W'(p) >> 5) ^ (ADDR_W'(p) >> 11);
            frame[p].red   = 4'(fold % RED_THRESHOLD);
            frame[p].green = fold[3:0];
            frame[p].blue  = fold[7:4];
        end
    endtask

    task automatic fill_block(input int col0, input int row0, input int width,
                              input int height, input pixel_t px);
        for (int r = row0; r < row0 + height; r++) begin
            for (int c = col0; c < col0 + width; c++) begin
                frame[r * IMAGE_WIDTH + c] = px;
            end
        end
    endtask

    // Roughly one bright pixel in odds survives
    task automatic fill_random(input int odds);
        pixel_t px;
        for (int p = 0; p < IMAGE_PIXELS; p++) begin
            px = 12'($random(seed));
            if (({$random(seed)} % odds) != 0) begin
                px.red = px.red % 4'(RED_THRESHOLD);
            end
            frame[p] = px;
        end
    endtask

    task automatic write_frame();
        for (int p = 0; p < IMAGE_PIXELS; p++) begin
            @(negedge clk);
            cam_in.valid = 1'b1;
            cam_in.last  = (p == IMAGE_PIXELS - 1);
            cam_in.data  = frame[p];
        end
        @(negedge clk);
        cam_in = '0;
    endtask

    task automatic run_frame(input string name, input direction_t expected);
        @(negedge clk);
        check_bit({name, " busy before write"}, 1'b0, busy);
        write_frame();
        while (!result_valid) begin
            @(negedge clk);
        end
        check_direction(name, expected, result);
    endtask

    task automatic reset_values();
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset result_valid", 1'b0, result_valid);
        check_bit("reset found", 1'b0, result.found);
    endtask

    task automatic dark_frames();
        clear_frame();
        run_frame("dark frame", direction_of(1'b0, 0));
        fill_block(150, 100, 3, 5, 12'hF00);    // 15 pixels, one short
        run_frame("15 bright pixels", direction_of(1'b0, 0));
    endtask

    task automatic single_blob_sweep();
        int bearings [NUM_DIVISIONS] = '{4, 12, 20};
        for (int d = 0; d < NUM_DIVISIONS; d++) begin
            clear_frame();
            fill_block(d * DIVISION_WIDTH + 40, 60 + 40 * d, 6, 6, 12'hA00);
            run_frame($sformatf("blob in division %0d", d), direction_of(1'b1, bearings[d]));
        end
    endtask

    task automatic competing_blobs();
        clear_frame();
        fill_block(10, 10, 5, 5, 12'hC00);      // 25 in division 0
        fill_block(250, 200, 6, 6, 12'hF0F);    // 36 in division 2
        run_frame("larger blob wins", direction_of(1'b1, 20));
        clear_frame();
        fill_block(120, 50, 5, 4, 12'hB00);
        fill_block(300, 50, 4, 5, 12'hB00);
        run_frame("tie between divisions 1 and 2", direction_of(1'b1, 12));
    endtask

    // Red 9 and pure green/blue must lose against 20 pixels at red 10
    task automatic threshold_levels();
        clear_frame();
        fill_block(20, 20, 8, 8, 12'h9FF);
        fill_block(150, 20, 5, 4, 12'hA00);
        fill_block(240, 20, 8, 8, 12'h0FF);
        run_frame("red threshold", direction_of(1'b1, 12));
    endtask

    task automatic division_edges();
        clear_frame();
        fill_block(106, 0, 1, 30, 12'hF00);
        fill_block(107, 0, 1, 20, 12'hF00);
        run_frame("column 106 in division 0", direction_of(1'b1, 4));
        clear_frame();
        fill_block(106, 0, 1, 20, 12'hF00);
        fill_block(107, 0, 1, 30, 12'hF00);
        run_frame("column 107 in division 1", direction_of(1'b1, 12));
    endtask

    task automatic random_frames();
        int odds [3] = '{1, 4096, 1024};
        direction_t expected;
        for (int k = 0; k < 3; k++) begin
            fill_random(odds[k]);
            predict_direction(expected);
            run_frame($sformatf("random frame %0d", k), expected);
        end
    endtask

    initial begin
        seed   = 75;
        errors = 0;
        rst    = 1'b1;
        cam_in = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reset_values();
        dark_frames();
        single_blob_sweep();
        competing_blobs();
        threshold_levels();
        division_edges();
        random_frames();
        repeat (4) @(negedge clk);
        if (errors == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Errors were found");
        end
    end

endmodule

//--- design/direction_top.sv
`timescale 1ns/100ps

module direction_top (
    input  logic                          clk,
    input  logic                          rst,
    input  direction_pkg::cam_pixel_t     cam_in,
    output logic                          busy,
    output direction_pkg::direction_t     result,
    output logic                          result_valid
);
    import direction_pkg::*;

    logic [ADDR_W-1:0] rd_addr;
    pixel_t            rd_data;
    logic              frame_ready;
    scan_sample_t      sample;
    division_counts_t  counts;
    logic              counts_valid;

    frame_buffer u_frame_buffer (
        .clk         (clk),
        .rst         (rst),
        .cam_in      (cam_in),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_ready (frame_ready)
    );

    // Sweeps the stored frame once per frame_ready
    frame_scanner u_frame_scanner (
        .clk         (clk),
        .rst         (rst),
        .frame_ready (frame_ready),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .sample      (sample),
        .busy        (busy)
    );

    division_histogram u_division_histogram (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .counts       (counts),
        .counts_valid (counts_valid)
    );

    direction_select u_direction_select (
        .clk          (clk),
        .rst          (rst),
        .counts       (counts),
        .counts_valid (counts_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- design/direction_select.sv
`timescale 1ns/100ps

module direction_select (
    input  logic                              clk,
    input  logic                              rst,
    input  direction_pkg::division_counts_t   counts,
    input  logic                              counts_valid,
    output direction_pkg::direction_t         result,
    output logic                              result_valid
);
    import direction_pkg::*;

    logic [DIV_IDX_W-1:0] best_idx;
    logic [COUNT_W-1:0]   best_count;
    logic                 found;
    logic [DEG_W-1:0]     bearing;

    // Argmax, strict compare keeps the lowest index on ties
    always_comb begin
        best_idx   = '0;
        best_count = counts[0];
        for (int i = 1; i < NUM_DIVISIONS; i++) begin
            if (counts[i] > best_count) begin
                best_count = counts[i];
                best_idx   = DIV_IDX_W'(i);
            end
        end
    end

    assign found   = (best_count >= COUNT_W'(MIN_OBJECT_PIXELS));
    assign bearing = DEG_W'(best_idx) * DEG_W'(FOV_DIVISION_DEG) + DEG_W'(BEARING_OFFSET_DEG);

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            result.found <= 1'b0;
        end else begin
            result_valid <= counts_valid;
            if (counts_valid) begin
                result.found <= found;
            end
        end
    end

    // Bearing is payload and holds until the next frame
    always_ff @(posedge clk) begin
        if (counts_valid) begin
            if (found) begin
                result.bearing <= bearing;
            end else begin
                result.bearing <= '0;   // No object
            end
        end
    end

    // One result per frame
    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |=> !result_valid
    ) else $error("result_valid high for two cycles");

endmodule

//--- design/division_histogram.sv
`timescale 1ns/100ps

module division_histogram (
    input  logic                              clk,
    input  logic                              rst,
    input  direction_pkg::scan_sample_t       sample,
    output direction_pkg::division_counts_t   counts,
    output logic                              counts_valid
);
    import direction_pkg::*;

    logic                 bright;
    logic [DIV_IDX_W-1:0] div_idx;
    division_counts_t     counts_next;

    // Only the red field decides
    assign bright = (sample.data.red >= 4'(RED_THRESHOLD));

    // Column to division with boundaries at multiples of DIVISION_WIDTH
    always_comb begin
        div_idx = '0;
        for (int i = 1; i < NUM_DIVISIONS; i++) begin
            if (sample.col >= COL_W'(i * DIVISION_WIDTH)) begin
                div_idx = DIV_IDX_W'(i);
            end
        end
    end

    // First pixel of a frame counts on top of cleared values
    always_comb begin
        for (int i = 0; i < NUM_DIVISIONS; i++) begin
            if (sample.first) begin
                counts_next[i] = '0;
            end else begin
                counts_next[i] = counts[i];
            end
            if (bright && (div_idx == DIV_IDX_W'(i))) begin
                counts_next[i] = counts_next[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample.valid) begin
            counts <= counts_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counts_valid <= 1'b0;
        end else begin
            counts_valid <= sample.valid && sample.last;    // Final counts are out now
        end
    end

    // Sample column lies inside the span of its division
    a_div_range: assert property (
        @(posedge clk) disable iff (rst)
        sample.valid |-> ((int'(sample.col) >= int'(div_idx) * DIVISION_WIDTH)
                          && (int'(sample.col) < (int'(div_idx) + 1) * DIVISION_WIDTH))
    ) else $error("Division index does not match the sample column");

endmodule

//--- design/frame_scanner.sv
`timescale 1ns/100ps

module frame_scanner (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              frame_ready,
    output logic [direction_pkg::ADDR_W-1:0]  rd_addr,
    input  direction_pkg::pixel_t             rd_data,
    output direction_pkg::scan_sample_t       sample,
    output logic                              busy
);
    import direction_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_SCAN
    } state_t;

    state_t state;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic issue_first;
    logic issue_last;
    logic start;

    // Pipeline stage matching the RAM read latency
    logic             valid_q;
    logic             first_q;
    logic             last_q;
    logic [COL_W-1:0] col_q;

    assign issue_first = (row == '0) && (col == '0);
    assign issue_last  = (row == ROW_W'(IMAGE_HEIGHT - 1)) && (col == COL_W'(IMAGE_WIDTH - 1));
    assign busy        = (state == S_SCAN) || valid_q;  // Held until the last sample is out
    assign start       = frame_ready && !busy;          // Late frame_ready is dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            rd_addr <= '0;
            col     <= '0;
            row     <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_SCAN;
                        rd_addr <= '0;
                        col     <= '0;
                        row     <= '0;
                    end
                end
                S_SCAN: begin
                    if (issue_last) begin
                        state <= S_IDLE;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                        if (col == COL_W'(IMAGE_WIDTH - 1)) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= (state == S_SCAN);
            first_q <= (state == S_SCAN) && issue_first;
            last_q  <= (state == S_SCAN) && issue_last;
        end
        col_q <= col;   // Payload, no reset
    end

    always_comb begin
        sample.valid = valid_q;
        sample.first = first_q;
        sample.last  = last_q;
        sample.col   = col_q;
        sample.data  = rd_data;
    end

    a_addr_range: assert property (
        @(posedge clk) disable iff (rst)
        (state == S_SCAN) |-> (rd_addr < IMAGE_PIXELS)
    ) else $error("Scan address beyond the frame");

    a_col_range: assert property (
        @(posedge clk) disable iff (rst)
        sample.valid |-> (sample.col < IMAGE_WIDTH)
    ) else $error("Sample column beyond the image width");

endmodule

//--- design/frame_buffer.sv
`timescale 1ns/100ps

module frame_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  direction_pkg::cam_pixel_t         cam_in,
    input  logic [direction_pkg::ADDR_W-1:0]  rd_addr,
    output direction_pkg::pixel_t             rd_data,
    output logic                              frame_ready
);
    import direction_pkg::*;

    pixel_t mem [IMAGE_PIXELS];     // One full frame
    logic [ADDR_W-1:0] wr_addr;

    // Raster write counter
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr     <= '0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= cam_in.valid && cam_in.last;
            if (cam_in.valid) begin
                if (cam_in.last) begin
                    wr_addr <= '0;      // Next frame starts at the top left
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cam_in.valid) begin
            mem[wr_addr] <= cam_in.data;
        end
        rd_data <= mem[rd_addr];        // Registered read
    end

    // Camera must close every frame on the final pixel slot
    a_frame_closed: assert property (
        @(posedge clk) disable iff (rst)
        cam_in.valid && (wr_addr == ADDR_W'(IMAGE_PIXELS - 1)) |-> cam_in.last
    ) else $error("Write address passed the end of the frame without a last pixel");

endmodule

//--- design/direction_pkg.sv
package direction_pkg;

    // Image geometry
    localparam int IMAGE_WIDTH  = 320;
    localparam int IMAGE_HEIGHT = 240;
    localparam int IMAGE_PIXELS = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int ADDR_W       = $clog2(IMAGE_PIXELS);     // 17 bits
    localparam int COL_W        = $clog2(IMAGE_WIDTH);      // 9 bits
    localparam int ROW_W        = $clog2(IMAGE_HEIGHT);     // 8 bits

    // Vertical divisions of the image, last one is narrower
    localparam int NUM_DIVISIONS  = 3;
    localparam int DIV_IDX_W      = $clog2(NUM_DIVISIONS);
    localparam int DIVISION_WIDTH = (IMAGE_WIDTH + NUM_DIVISIONS - 1) / NUM_DIVISIONS;

    // Camera field of view
    localparam int FOV_DEG            = 25;
    localparam int DEG_W              = 5;
    localparam int FOV_DIVISION_DEG   = FOV_DEG / NUM_DIVISIONS;  // 8 degrees
    localparam int BEARING_OFFSET_DEG = FOV_DIVISION_DEG / 2;     // Centre of a division

    // Detection rules
    localparam int RED_THRESHOLD     = 10;
    localparam int MIN_OBJECT_PIXELS = 16;
    localparam int COUNT_W           = $clog2(IMAGE_PIXELS + 1);

    typedef struct packed {
        logic [3:0] red;    // Bits 11:8
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;

    // Camera write strobe
    typedef struct packed {
        logic   valid;
        logic   last;      // Final pixel of a frame
        pixel_t data;
    } cam_pixel_t;

    // Pixel sample from the scanner, aligned with RAM read data
    typedef struct packed {
        logic             valid;
        logic             first;
        logic             last;
        logic [COL_W-1:0] col;
        pixel_t           data;
    } scan_sample_t;

    typedef logic [NUM_DIVISIONS-1:0][COUNT_W-1:0] division_counts_t;

    typedef struct packed {
        logic             found;
        logic [DEG_W-1:0] bearing;  // Degrees inside the FOV
    } direction_t;

endpackage
